/* include/krv_defines.svh */
// Word-only AHB-lite map: region code in haddr[15:12], register word in haddr[3:2]
`ifndef KRV_DEFINES_SVH
`define KRV_DEFINES_SVH

// Bus widths
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// Interrupt sources, one per GPIO pin
`define INT_NUM 8

// Region codes, anything else is unmapped
`define REGION_GPIO  4'h0
`define REGION_TIMER 4'h1
`define REGION_KPLIC 4'h2

// GPIO registers
`define GPIO_OUT_OFS 2'd0
`define GPIO_IN_OFS  2'd1

// Machine timer registers
`define MTIME_LO_OFS    2'd0
`define MTIME_HI_OFS    2'd1
`define MTIMECMP_LO_OFS 2'd2
`define MTIMECMP_HI_OFS 2'd3

// Interrupt controller registers
`define KPLIC_PEND_OFS  2'd0
`define KPLIC_EN_OFS    2'd1
`define KPLIC_CLAIM_OFS 2'd2

`endif

/* verilog/krv_pkg.sv */
// Bus types and decoder phases; widths come from krv_defines.svh, only IDLE and NONSEQ are used
`include "krv_defines.svh"

package krv_pkg;

	// Bus vectors
	typedef logic [`AHB_ADDR_WIDTH-1:0] ahb_addr_t;
	typedef logic [`AHB_DATA_WIDTH-1:0] ahb_data_t;
	typedef logic [1:0] htrans_t;
	typedef logic hresp_t;

	// One bit per interrupt source or GPIO pin
	typedef logic [`INT_NUM-1:0] int_vec_t;

	localparam htrans_t HTRANS_IDLE = 2'b00;
	localparam htrans_t HTRANS_NONSEQ = 2'b10;

	localparam hresp_t HRESP_OKAY = 1'b0;
	localparam hresp_t HRESP_ERROR = 1'b1;

	// Two-cycle error response of the decoder
	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_ERR1,
		DEC_ERR2
	} dec_phase_t;

endpackage

/* verilog/ahb_slave_if.sv */
// Data-phase AHB-lite bundle from the decoder to one slave; haddr is already registered
interface ahb_slave_if;
	import krv_pkg::*;

	// Select, high for the whole data phase
	logic hsel;

	// Registered address of the transfer
	ahb_addr_t haddr;

	logic hwrite;

	// Write data straight from the master in the data phase
	ahb_data_t hwdata;

	// Read data, muxed by the decoder
	ahb_data_t hrdata;

	modport decoder (
		output hsel,
		output haddr,
		output hwrite,
		output hwdata,
		input  hrdata
	);

	modport slave (
		input  hsel,
		input  haddr,
		input  hwrite,
		input  hwdata,
		output hrdata
	);

endinterface

/* verilog/ahb_decoder.sv */
// Single-master decoder, no wait states from slaves; unmapped regions get a two-cycle ERROR
`include "krv_defines.svh"

module ahb_decoder (
	input  logic               clk_in,
	input  logic               rst_n,
	input  logic               hsel,
	input  krv_pkg::ahb_addr_t haddr,
	input  krv_pkg::htrans_t   htrans,
	input  logic               hwrite,
	input  krv_pkg::ahb_data_t hwdata,
	output krv_pkg::ahb_data_t hrdata,
	output logic               hready,
	output krv_pkg::hresp_t    hresp,
	ahb_slave_if.decoder       s_gpio,
	ahb_slave_if.decoder       s_timer,
	ahb_slave_if.decoder       s_kplic
);
	import krv_pkg::*;

	dec_phase_t phase;
	logic accept;
	logic [3:0] region;
	logic hit_gpio;
	logic hit_timer;
	logic hit_kplic;
	logic unmapped;
	logic sel_gpio_q;
	logic sel_timer_q;
	logic sel_kplic_q;
	logic write_q;
	ahb_addr_t addr_q;

	// Address phase
	assign accept = hsel && (htrans == HTRANS_NONSEQ) && hready;
	assign region = haddr[15:12];
	assign hit_gpio = (region == `REGION_GPIO);
	assign hit_timer = (region == `REGION_TIMER);
	assign hit_kplic = (region == `REGION_KPLIC);
	assign unmapped = !(hit_gpio || hit_timer || hit_kplic);

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			sel_gpio_q <= 1'b0;
			sel_timer_q <= 1'b0;
			sel_kplic_q <= 1'b0;
			write_q <= 1'b0;
		end else begin
			sel_gpio_q <= accept && hit_gpio;
			sel_timer_q <= accept && hit_timer;
			sel_kplic_q <= accept && hit_kplic;
			write_q <= accept && hwrite;
		end
	end

	always_ff @(posedge clk_in) begin
		if (accept)
			addr_q <= haddr;
	end

	// Error phases, ERR1 stalls the master
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			phase <= DEC_IDLE;
		end else begin
			case (phase)
				DEC_ERR1: phase <= DEC_ERR2;
				default:  phase <= (accept && unmapped) ? DEC_ERR1 : DEC_IDLE;
			endcase
		end
	end

	assign hready = (phase != DEC_ERR1);
	assign hresp = (phase == DEC_IDLE) ? HRESP_OKAY : HRESP_ERROR;

	// Data phase towards the slaves
	assign s_gpio.hsel = sel_gpio_q;
	assign s_gpio.haddr = addr_q;
	assign s_gpio.hwrite = write_q;
	assign s_gpio.hwdata = hwdata;
	assign s_timer.hsel = sel_timer_q;
	assign s_timer.haddr = addr_q;
	assign s_timer.hwrite = write_q;
	assign s_timer.hwdata = hwdata;
	assign s_kplic.hsel = sel_kplic_q;
	assign s_kplic.haddr = addr_q;
	assign s_kplic.hwrite = write_q;
	assign s_kplic.hwdata = hwdata;

	always_comb begin
		if (sel_gpio_q)
			hrdata = s_gpio.hrdata;
		else if (sel_timer_q)
			hrdata = s_timer.hrdata;
		else if (sel_kplic_q)
			hrdata = s_kplic.hrdata;
		else
			hrdata = '0;
	end

	a_one_slave: assert property (@(posedge clk_in) disable iff (!rst_n)
		$onehot0({sel_gpio_q, sel_timer_q, sel_kplic_q}));

	// Stall lasts one cycle and is followed by the second ERROR cycle
	a_err_stall: assert property (@(posedge clk_in) disable iff (!rst_n)
		!hready |-> (phase == DEC_ERR1) ##1 (hready && hresp == HRESP_ERROR));

endmodule

/* verilog/core_timer.sv */
// 64-bit machine timer counting every clk_in; halves are written separately, no atomic update
`include "krv_defines.svh"

module core_timer (
	input  logic       clk_in,
	input  logic       rst_n,
	ahb_slave_if.slave bus,
	output logic       core_timer_int
);
	import krv_pkg::*;

	logic [63:0] mtime;
	logic [63:0] mtimecmp;
	logic [1:0] ofs;
	logic wr_en;
	logic mtime_wr;
	ahb_data_t rdata;

	assign ofs = bus.haddr[3:2];
	assign wr_en = bus.hsel && bus.hwrite;
	assign mtime_wr = wr_en && (ofs == `MTIME_LO_OFS || ofs == `MTIME_HI_OFS);

	// Free-running counter, a write replaces one half
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && ofs == `MTIME_LO_OFS) begin
			mtime <= {mtime[63:32], bus.hwdata};
		end else if (wr_en && ofs == `MTIME_HI_OFS) begin
			mtime <= {bus.hwdata, mtime[31:0]};
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	// All ones keeps the interrupt off
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else if (wr_en && ofs == `MTIMECMP_LO_OFS) begin
			mtimecmp <= {mtimecmp[63:32], bus.hwdata};
		end else if (wr_en && ofs == `MTIMECMP_HI_OFS) begin
			mtimecmp <= {bus.hwdata, mtimecmp[31:0]};
		end
	end

	// Level interrupt, one cycle behind the compare
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n)
			core_timer_int <= 1'b0;
		else
			core_timer_int <= (mtime >= mtimecmp);
	end

	always_comb begin
		case (ofs)
			`MTIME_LO_OFS:    rdata = mtime[31:0];
			`MTIME_HI_OFS:    rdata = mtime[63:32];
			`MTIMECMP_LO_OFS: rdata = mtimecmp[31:0];
			default:          rdata = mtimecmp[63:32];
		endcase
	end

	assign bus.hrdata = rdata;

	a_mtime_step: assert property (@(posedge clk_in) disable iff (!rst_n)
		!mtime_wr |=> mtime == $past(mtime) + 64'd1);

endmodule

/* verilog/kplic.sv */
// Edge-fed interrupt controller without priorities or thresholds; the lowest source id wins
`include "krv_defines.svh"

module kplic (
	input  logic              clk_in,
	input  logic              rst_n,
	ahb_slave_if.slave        bus,
	input  krv_pkg::int_vec_t external_int,
	output logic              kplic_int
);
	import krv_pkg::*;

	int_vec_t pending;
	int_vec_t enable;
	int_vec_t pend_nxt;
	int_vec_t en_nxt;
	int_vec_t claim_mask;
	ahb_data_t claim_id;
	ahb_data_t rdata;
	logic [1:0] ofs;
	logic wr_en;
	logic claim_rd;

	assign ofs = bus.haddr[3:2];
	assign wr_en = bus.hsel && bus.hwrite;
	assign claim_rd = bus.hsel && !bus.hwrite && (ofs == `KPLIC_CLAIM_OFS);

	// Scan downwards so the lowest enabled pending source is left
	always_comb begin
		claim_mask = '0;
		claim_id = '0;
		for (int i = `INT_NUM - 1; i >= 0; i--) begin
			if (pending[i] && enable[i]) begin
				claim_mask = '0;
				claim_mask[i] = 1'b1;
				claim_id = ahb_data_t'(i + 1);
			end
		end
	end

	always_comb begin
		pend_nxt = pending;
		en_nxt = enable;
		// Write 1 to clear
		if (wr_en && ofs == `KPLIC_PEND_OFS)
			pend_nxt = pend_nxt & ~int_vec_t'(bus.hwdata);
		if (wr_en && ofs == `KPLIC_EN_OFS)
			en_nxt = int_vec_t'(bus.hwdata);
		if (claim_rd)
			pend_nxt = pend_nxt & ~claim_mask;
		// A new edge beats a clear in the same cycle
		pend_nxt = pend_nxt | external_int;
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
			enable <= '0;
			kplic_int <= 1'b0;
		end else begin
			pending <= pend_nxt;
			enable <= en_nxt;
			kplic_int <= |(pend_nxt & en_nxt);
		end
	end

	always_comb begin
		case (ofs)
			`KPLIC_PEND_OFS:  rdata = ahb_data_t'(pending);
			`KPLIC_EN_OFS:    rdata = ahb_data_t'(enable);
			`KPLIC_CLAIM_OFS: rdata = claim_id;
			default:          rdata = '0;
		endcase
	end

	assign bus.hrdata = rdata;

	a_int_source: assert property (@(posedge clk_in) disable iff (!rst_n)
		kplic_int |-> |(pending & enable));

endmodule

/* verilog/gpio.sv */
// GPIO with asynchronous inputs; edge pulses come 3 clocks after a gpio_in rise
`include "krv_defines.svh"

module gpio (
	input  logic              clk_in,
	input  logic              rst_n,
	ahb_slave_if.slave        bus,
	input  krv_pkg::int_vec_t gpio_in,
	output krv_pkg::int_vec_t gpio_out,
	output krv_pkg::int_vec_t edge_int
);
	import krv_pkg::*;

	int_vec_t sync1;
	int_vec_t sync2;
	int_vec_t sync_prev;
	logic [1:0] ofs;

	assign ofs = bus.haddr[3:2];

	// Output register
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n)
			gpio_out <= '0;
		else if (bus.hsel && bus.hwrite && ofs == `GPIO_OUT_OFS)
			gpio_out <= int_vec_t'(bus.hwdata);
	end

	// Two-stage synchronizer, then edge detect
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			sync_prev <= '0;
			edge_int <= '0;
		end else begin
			sync1 <= gpio_in;
			sync2 <= sync1;
			sync_prev <= sync2;
			edge_int <= sync2 & ~sync_prev;
		end
	end

	always_comb begin
		case (ofs)
			`GPIO_OUT_OFS: bus.hrdata = ahb_data_t'(gpio_out);
			`GPIO_IN_OFS:  bus.hrdata = ahb_data_t'(sync2);
			default:       bus.hrdata = '0;
		endcase
	end

endmodule

/* verilog/krv_periph.sv */
// Peripheral subsystem top for one external AHB-lite master; word accesses only, one clock
module krv_periph (
	input  logic               clk_in,
	input  logic               rst_n,

	// AHB-lite slave port
	input  logic               hsel,
	input  krv_pkg::ahb_addr_t haddr,
	input  krv_pkg::htrans_t   htrans,
	input  logic               hwrite,
	input  krv_pkg::ahb_data_t hwdata,
	output krv_pkg::ahb_data_t hrdata,
	output logic               hready,
	output krv_pkg::hresp_t    hresp,

	// Pins and interrupts
	input  krv_pkg::int_vec_t  gpio_in,
	output krv_pkg::int_vec_t  gpio_out,
	output logic               kplic_int,
	output logic               core_timer_int
);
	import krv_pkg::*;

	// GPIO edges into the interrupt controller
	int_vec_t gpio_edge;

	ahb_slave_if s_gpio ();
	ahb_slave_if s_timer ();
	ahb_slave_if s_kplic ();

	ahb_decoder u_ahb_decoder (
		.clk_in  (clk_in),
		.rst_n   (rst_n),
		.hsel    (hsel),
		.haddr   (haddr),
		.htrans  (htrans),
		.hwrite  (hwrite),
		.hwdata  (hwdata),
		.hrdata  (hrdata),
		.hready  (hready),
		.hresp   (hresp),
		.s_gpio  (s_gpio),
		.s_timer (s_timer),
		.s_kplic (s_kplic)
	);

	core_timer u_core_timer (
		.clk_in         (clk_in),
		.rst_n          (rst_n),
		.bus            (s_timer),
		.core_timer_int (core_timer_int)
	);

	gpio u_gpio (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.bus      (s_gpio),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.edge_int (gpio_edge)
	);

	kplic u_kplic (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.bus          (s_kplic),
		.external_int (gpio_edge),
		.kplic_int    (kplic_int)
	);

endmodule

/* testbench/tb_krv_periph.sv */
// Single AHB-lite master fed from testbench/tb_input.txt; run from the project root, words only
module tb_krv_periph;
	timeunit 1ns;
	timeprecision 1ps;
	import krv_pkg::*;

	localparam int MAX_CMD = 64;

	logic clk_in = 1'b0;
	logic rst_n;
	logic hsel;
	ahb_addr_t haddr;
	htrans_t htrans;
	logic hwrite;
	ahb_data_t hwdata;
	ahb_data_t hrdata;
	logic hready;
	hresp_t hresp;
	int_vec_t gpio_in;
	int_vec_t gpio_out;
	logic kplic_int;
	logic core_timer_int;

	// Four words per command line
	logic [31:0] cmd_mem [0:4*MAX_CMD-1];
	int n_cmd;
	int cycle_cnt = 0;
	int cycle_limit = 200;
	ahb_data_t last_mtime;

	krv_periph dut0 (
		.clk_in         (clk_in),
		.rst_n          (rst_n),
		.hsel           (hsel),
		.haddr          (haddr),
		.htrans         (htrans),
		.hwrite         (hwrite),
		.hwdata         (hwdata),
		.hrdata         (hrdata),
		.hready         (hready),
		.hresp          (hresp),
		.gpio_in        (gpio_in),
		.gpio_out       (gpio_out),
		.kplic_int      (kplic_int),
		.core_timer_int (core_timer_int)
	);

	always #20 clk_in = ~clk_in;

	always @(posedge clk_in) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the test did not finish within %0d cycles", cycle_limit);
			stop_on_failure();
		end
	end

	task automatic stop_on_failure();
		$display("Verification failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input ahb_data_t got, input ahb_data_t exp);
		assert (got === exp) else begin
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_failure();
		end
	endtask

	// Data phase is sampled at the falling edge
	task automatic bus_read(input ahb_addr_t addr, output ahb_data_t data, output hresp_t resp);
		@(posedge clk_in);
		hsel <= 1'b1;
		haddr <= addr;
		htrans <= HTRANS_NONSEQ;
		hwrite <= 1'b0;
		@(posedge clk_in);
		hsel <= 1'b0;
		htrans <= HTRANS_IDLE;
		@(negedge clk_in);
		data = hrdata;
		resp = hresp;
	endtask

	task automatic bus_write(input ahb_addr_t addr, input ahb_data_t data);
		@(posedge clk_in);
		hsel <= 1'b1;
		haddr <= addr;
		htrans <= HTRANS_NONSEQ;
		hwrite <= 1'b1;
		@(posedge clk_in);
		hsel <= 1'b0;
		htrans <= HTRANS_IDLE;
		hwrite <= 1'b0;
		hwdata <= data;
		@(negedge clk_in);
		check_word("hresp", ahb_data_t'(hresp), ahb_data_t'(HRESP_OKAY));
	endtask

	// Unmapped access gives a stalled ERROR cycle and then a second one
	task automatic bus_error(input ahb_addr_t addr);
		@(posedge clk_in);
		hsel <= 1'b1;
		haddr <= addr;
		htrans <= HTRANS_NONSEQ;
		hwrite <= 1'b0;
		@(posedge clk_in);
		hsel <= 1'b0;
		htrans <= HTRANS_IDLE;
		@(negedge clk_in);
		check_word("hready", ahb_data_t'(hready), 32'h0);
		check_word("hresp", ahb_data_t'(hresp), ahb_data_t'(HRESP_ERROR));
		@(negedge clk_in);
		check_word("hready", ahb_data_t'(hready), 32'h1);
		check_word("hresp", ahb_data_t'(hresp), ahb_data_t'(HRESP_ERROR));
	endtask

	// Waits out the sync stages plus the edge and pending registers
	task automatic drive_pins(input ahb_data_t value);
		@(posedge clk_in);
		gpio_in <= int_vec_t'(value);
		repeat (4) @(posedge clk_in);
		@(negedge clk_in);
	endtask

	task automatic wait_irq(input ahb_data_t sel, input ahb_data_t limit, input logic level);
		int cnt;
		logic seen;
		cnt = 0;
		seen = (((sel == 32'd0) ? kplic_int : core_timer_int) == level);
		while (!seen && cnt < limit) begin
			@(negedge clk_in);
			cnt++;
			seen = (((sel == 32'd0) ? kplic_int : core_timer_int) == level);
		end
		assert (seen) else begin
			$display("Interrupt %0d did not reach level %0d within %0d cycles", sel, level, limit);
			stop_on_failure();
		end
	endtask

	task automatic random_out(input ahb_addr_t addr);
		int_vec_t value;
		ahb_data_t rd;
		hresp_t resp;
		value = int_vec_t'($urandom);
		bus_write(addr, ahb_data_t'(value));
		@(negedge clk_in);
		check_word("gpio_out", ahb_data_t'(gpio_out), ahb_data_t'(value));
		bus_read(addr, rd, resp);
		check_word("hresp", ahb_data_t'(resp), ahb_data_t'(HRESP_OKAY));
		check_word("hrdata", rd, ahb_data_t'(value));
	endtask

	task automatic mtime_step(input ahb_addr_t addr, input ahb_data_t gap);
		ahb_data_t first;
		ahb_data_t second;
		hresp_t resp;
		bus_read(addr, first, resp);
		check_word("hresp", ahb_data_t'(resp), ahb_data_t'(HRESP_OKAY));
		repeat (gap) @(posedge clk_in);
		bus_read(addr, second, resp);
		check_word("hresp", ahb_data_t'(resp), ahb_data_t'(HRESP_OKAY));
		assert (second > first) else begin
			$display("** Error: mtime_lo = 0x%08h, expected above 0x%08h", second, first);
			stop_on_failure();
		end
		last_mtime = second;
	endtask

	task automatic run_command(input logic [31:0] op, input ahb_addr_t addr,
		input ahb_data_t data, input ahb_data_t exp);
		ahb_data_t rd;
		hresp_t resp;
		case (op)
			32'd1: bus_write(addr, data);
			32'd2: begin
				bus_read(addr, rd, resp);
				check_word("hresp", ahb_data_t'(resp), ahb_data_t'(HRESP_OKAY));
				check_word("hrdata", rd & data, exp);
			end
			32'd3: bus_error(addr);
			32'd4: drive_pins(data);
			32'd5: wait_irq(addr, data, exp[0]);
			32'd6: random_out(addr);
			32'd7: mtime_step(addr, data);
			// Compare value relative to the last mtime read
			32'd8: bus_write(addr, last_mtime + data);
			default: begin
				$display("Unknown operation %0h in testbench/tb_input.txt", op);
				stop_on_failure();
			end
		endcase
	endtask

	initial begin
		int seed_ret;
		rst_n = 1'b0;
		hsel = 1'b0;
		haddr = '0;
		htrans = HTRANS_IDLE;
		hwrite = 1'b0;
		hwdata = '0;
		gpio_in = '0;
		seed_ret = $urandom(38722);

		for (int i = 0; i < 4 * MAX_CMD; i++)
			cmd_mem[i] = '0;
		$readmemh("testbench/tb_input.txt", cmd_mem);
		n_cmd = 0;
		while (n_cmd < MAX_CMD && cmd_mem[4*n_cmd] != 32'h0)
			n_cmd++;
		assert (n_cmd > 0) else begin
			$display("No commands read from testbench/tb_input.txt");
			stop_on_failure();
		end
		cycle_limit = 20 * n_cmd + 200;

		repeat (3) @(posedge clk_in);
		rst_n <= 1'b1;
		@(negedge clk_in);
		check_word("hready", ahb_data_t'(hready), 32'h1);
		check_word("hresp", ahb_data_t'(hresp), ahb_data_t'(HRESP_OKAY));
		check_word("gpio_out", ahb_data_t'(gpio_out), 32'h0);
		check_word("kplic_int", ahb_data_t'(kplic_int), 32'h0);
		check_word("core_timer_int", ahb_data_t'(core_timer_int), 32'h0);

		for (int i = 0; i < n_cmd; i++)
			run_command(cmd_mem[4*i], cmd_mem[4*i+1], cmd_mem[4*i+2], cmd_mem[4*i+3]);

		$display("Verification passed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
verilog/krv_pkg.sv
verilog/ahb_slave_if.sv
verilog/ahb_decoder.sv
verilog/core_timer.sv
verilog/kplic.sv
verilog/gpio.sv
verilog/krv_periph.sv
testbench/tb_krv_periph.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_krv_periph -f filelist.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"

/* testbench/tb_input.txt */
// op addr data expect, all hex; op 1 write, 2 read (data is a mask), 3 error, 4 gpio_in level
// op 5 wait irq (addr 0 kplic, 1 timer; data cycles), 6 random gpio_out, 7 mtime step, 8 arm
00000002 00002008 ffffffff 00000000
00000006 00000000 00000000 00000000
00000004 00000000 00000081 00000000
00000002 00000004 ffffffff 00000081
00000001 00002004 00000024 00000000
00000002 00002000 ffffffff 00000081
00000004 00000000 000000a5 00000000
00000005 00000000 0000000a 00000001
00000002 00002000 ffffffff 000000a5
00000002 00002008 ffffffff 00000003
00000002 00002008 ffffffff 00000006
00000005 00000000 00000003 00000000
00000002 00002008 ffffffff 00000000
00000001 00002000 000000ff 00000000
00000002 00002000 ffffffff 00000000
00000004 00000000 000000e5 00000000
00000002 00002000 ffffffff 00000040
00000005 00000000 00000001 00000000
00000001 0000100c 00000000 00000000
00000007 00001000 00000005 00000000
00000008 00001008 00000014 00000000
00000005 00000001 00000028 00000001
00000001 0000100c ffffffff 00000000
00000001 00001008 ffffffff 00000000
00000005 00000001 00000003 00000000
00000003 00007000 00000000 00000000
00000002 00002004 ffffffff 00000024
